// ==== hdl/net_pkg.sv ====
//////////////////////////////
// packet format types and constants
// ethernet + single mpls entry, byte stream beat
//////////////////////////////

package net_pkg;

    // scalar field types
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [19:0] mpls_label_t;
    typedef logic [2:0]  mpls_tc_t;
    typedef logic [7:0]  mpls_ttl_t;

    // header geometry
    localparam int HDR_BYTES = 18;
    localparam int HDR_BITS  = HDR_BYTES * 8;

    // byte position inside the 18 byte header
    typedef logic [4:0] hdr_idx_t;

    localparam ether_type_t ETHERTYPE_MPLS = 16'h8847;

    // one stream beat, 9 bits
    typedef struct packed {
        byte_t data;
        logic  last;
    } axis_beat_t;

    // hdr_last sits above the wire bytes
    // so bits [HDR_BITS-1:0] are the header in wire order, first byte on top
    typedef struct packed {
        logic        hdr_last;
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        ether_type_t ether_type;
        mpls_label_t label;
        mpls_tc_t    tc;
        logic        bos;
        mpls_ttl_t   ttl;
    } eth_mpls_hdr_t;

endpackage

// ==== hdl/router_pkg.sv ====
//////////////////////////////
// forwarding config: ports, label table, macs
//////////////////////////////

package router_pkg;

    localparam int NUM_EGR_PORTS = 2;
    localparam int LABEL_ENTRIES = 4;

    typedef logic [0:0] port_idx_t;

    // one row of the label table
    typedef struct packed {
        net_pkg::mpls_label_t in_label;
        net_pkg::mpls_label_t out_label;
        port_idx_t            port;
    } label_entry_t;

    // constant lfib, no control plane
    localparam label_entry_t LABEL_TABLE [LABEL_ENTRIES] = '{
        '{in_label: 20'h00100, out_label: 20'h01100, port: 1'b0},
        '{in_label: 20'h00200, out_label: 20'h01200, port: 1'b1},
        '{in_label: 20'h00300, out_label: 20'h01300, port: 1'b0},
        '{in_label: 20'h00400, out_label: 20'h01400, port: 1'b1}
    };

    // our own source mac
    localparam net_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_5e_10_00_01;

    // next hop per egress port
    localparam net_pkg::mac_addr_t NEXT_HOP_MAC [NUM_EGR_PORTS] = '{
        48'h02_00_5e_20_00_0a,
        48'h02_00_5e_20_00_0b
    };

    // forwarding decision plus rewritten header
    typedef struct packed {
        logic                   drop;
        port_idx_t              port;
        net_pkg::eth_mpls_hdr_t hdr;
    } fwd_action_t;

endpackage

// ==== hdl/mpls_hdr_decode.sv ====
//////////////////////////////
// header collector, runt filter, payload pass
//////////////////////////////

`timescale 1ns/1ps

module mpls_hdr_decode (
    input  logic                   core_clk_ifc,
    input  logic                   arst_n,
    // ingress stream
    input  net_pkg::axis_beat_t    in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    // parsed header to execute
    output net_pkg::eth_mpls_hdr_t hdr,
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    // payload to egress
    output net_pkg::axis_beat_t    pay_beat,
    output logic                   pay_valid,
    input  logic                   pay_ready,
    output logic [15:0]            runt_count
);

    typedef enum logic [1:0] {
        ST_COLLECT,
        ST_HOLD_HDR,
        ST_PAYLOAD
    } state_t;

    localparam net_pkg::hdr_idx_t LAST_IDX = net_pkg::hdr_idx_t'(net_pkg::HDR_BYTES - 1);

    state_t                        state;
    logic                          armed;
    net_pkg::hdr_idx_t             byte_cnt;
    logic [net_pkg::HDR_BITS-1:0]  hdr_bits;
    logic                          hdr_last_q;
    logic                          in_xfer;

    // ready only once out of reset
    assign in_ready  = (state == ST_COLLECT && armed) || (state == ST_PAYLOAD && pay_ready);
    assign in_xfer   = in_valid && in_ready;
    assign hdr_valid = (state == ST_HOLD_HDR);
    assign hdr       = net_pkg::eth_mpls_hdr_t'({hdr_last_q, hdr_bits});
    // payload goes straight through
    assign pay_beat  = in_beat;
    assign pay_valid = (state == ST_PAYLOAD) && in_valid;

    //////////////////////////////
    // control fsm
    //////////////////////////////
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_COLLECT;
            armed      <= 1'b0;
            byte_cnt   <= '0;
            runt_count <= '0;
        end else begin
            armed <= 1'b1;
            case (state)
                ST_COLLECT: begin
                    if (in_xfer) begin
                        if (byte_cnt == LAST_IDX) begin
                            // full header where last may also land
                            byte_cnt <= '0;
                            state    <= ST_HOLD_HDR;
                        end else if (in_beat.last) begin
                            // runt is thrown away
                            byte_cnt   <= '0;
                            runt_count <= runt_count + 16'd1;
                        end else begin
                            byte_cnt <= byte_cnt + 5'd1;
                        end
                    end
                end
                ST_HOLD_HDR: begin
                    if (hdr_ready) begin
                        // header-only packet has no payload
                        state <= hdr_last_q ? ST_COLLECT : ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (in_xfer && in_beat.last) begin
                        state <= ST_COLLECT;
                    end
                end
                default: begin
                    state <= ST_COLLECT;
                end
            endcase
        end
    end

    // header shift register
    always_ff @(posedge core_clk_ifc) begin
        if (state == ST_COLLECT && in_xfer) begin
            hdr_bits   <= {hdr_bits[net_pkg::HDR_BITS-9:0], in_beat.data};
            hdr_last_q <= in_beat.last;
        end
    end

    // payload handshake only while streaming
    a_pay_in_payload: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        pay_valid |-> state == ST_PAYLOAD);

endmodule

// ==== hdl/label_switch_execute.sv ====
//////////////////////////////
// label lookup, ttl check, action register
//////////////////////////////

`timescale 1ns/1ps

module label_switch_execute (
    input  logic                    core_clk_ifc,
    input  logic                    arst_n,
    input  net_pkg::eth_mpls_hdr_t  hdr,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    output router_pkg::fwd_action_t act,
    output logic                    act_valid,
    input  logic                    act_ready,
    output logic [15:0]             drop_count
);

    logic                    hit;
    net_pkg::mpls_label_t    out_label;
    router_pkg::port_idx_t   out_port;
    logic                    drop;
    router_pkg::fwd_action_t next_act;
    logic                    hdr_xfer;

    // one-deep register, refill while draining
    assign hdr_ready = !act_valid || act_ready;
    assign hdr_xfer  = hdr_valid && hdr_ready;

    // table search, first match wins
    always_comb begin
        hit       = 1'b0;
        out_label = '0;
        out_port  = '0;
        for (int i = 0; i < router_pkg::LABEL_ENTRIES; i++) begin
            if (!hit && hdr.label == router_pkg::LABEL_TABLE[i].in_label) begin
                hit       = 1'b1;
                out_label = router_pkg::LABEL_TABLE[i].out_label;
                out_port  = router_pkg::LABEL_TABLE[i].port;
            end
        end
    end

    // not mpls, unknown label or ttl expiring
    assign drop = (hdr.ether_type != net_pkg::ETHERTYPE_MPLS) || !hit
                  || (hdr.ttl <= net_pkg::mpls_ttl_t'(1));

    // rewritten header, tc and bos ride along
    always_comb begin
        next_act             = '0;
        next_act.drop        = drop;
        next_act.port        = out_port;
        next_act.hdr         = hdr;
        next_act.hdr.dst_mac = router_pkg::NEXT_HOP_MAC[out_port];
        next_act.hdr.src_mac = router_pkg::LOCAL_MAC;
        next_act.hdr.label   = out_label;
        next_act.hdr.ttl     = hdr.ttl - net_pkg::mpls_ttl_t'(1);
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            act_valid  <= 1'b0;
            drop_count <= '0;
        end else if (hdr_xfer) begin
            act_valid <= 1'b1;
            if (drop) begin
                drop_count <= drop_count + 16'd1;
            end
        end else if (act_ready) begin
            act_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (hdr_xfer) begin
            act <= next_act;
        end
    end

    // action must not move under a stalled egress
    a_act_stable: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        act_valid && !act_ready |=> act_valid && $stable(act));

endmodule

// ==== hdl/egress_rewrite.sv ====
//////////////////////////////
// header serializer and egress port steering
//////////////////////////////

`timescale 1ns/1ps

module egress_rewrite (
    input  logic                                                core_clk_ifc,
    input  logic                                                arst_n,
    input  router_pkg::fwd_action_t                             act,
    input  logic                                                act_valid,
    output logic                                                act_ready,
    input  net_pkg::axis_beat_t                                 pay_beat,
    input  logic                                                pay_valid,
    output logic                                                pay_ready,
    output net_pkg::axis_beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    output logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_valid,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND_HDR,
        ST_FORWARD,
        ST_DISCARD
    } state_t;

    localparam net_pkg::hdr_idx_t LAST_IDX = net_pkg::hdr_idx_t'(net_pkg::HDR_BYTES - 1);

    state_t                        state;
    router_pkg::fwd_action_t       cur;
    net_pkg::hdr_idx_t             hdr_idx;
    logic [net_pkg::HDR_BITS-1:0]  hdr_bits;
    net_pkg::axis_beat_t           out_beat;
    logic                          out_valid;
    logic                          port_ready;
    logic                          egr_xfer;
    logic                          last_hdr_byte;

    // wire-order bytes of the latched header
    assign hdr_bits      = cur.hdr[net_pkg::HDR_BITS-1:0];
    assign last_hdr_byte = (hdr_idx == LAST_IDX);
    assign port_ready    = egr_ready[cur.port];
    assign act_ready     = (state == ST_IDLE);
    assign egr_xfer      = out_valid && port_ready;

    // mux header byte or payload beat
    always_comb begin
        out_beat.data = hdr_bits[net_pkg::HDR_BITS-1 - 8*int'(hdr_idx) -: 8];
        out_beat.last = last_hdr_byte && cur.hdr.hdr_last;
        out_valid     = 1'b0;
        pay_ready     = 1'b0;
        case (state)
            ST_SEND_HDR: begin
                out_valid = 1'b1;
            end
            ST_FORWARD: begin
                out_beat  = pay_beat;
                out_valid = pay_valid;
                pay_ready = port_ready;
            end
            ST_DISCARD: begin
                // swallow the payload
                pay_ready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // data broadcast, valid only on the chosen port
    always_comb begin
        for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
            egr_beat[p]  = out_beat;
            egr_valid[p] = out_valid && (cur.port == router_pkg::port_idx_t'(p));
        end
    end

    //////////////////////////////
    // sequencing
    //////////////////////////////
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            hdr_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (act_valid) begin
                        hdr_idx <= '0;
                        if (!act.drop) begin
                            state <= ST_SEND_HDR;
                        end else if (!act.hdr.hdr_last) begin
                            state <= ST_DISCARD;
                        end
                    end
                end
                ST_SEND_HDR: begin
                    if (egr_xfer) begin
                        if (last_hdr_byte) begin
                            state <= cur.hdr.hdr_last ? ST_IDLE : ST_FORWARD;
                        end else begin
                            hdr_idx <= hdr_idx + 5'd1;
                        end
                    end
                end
                ST_FORWARD: begin
                    if (egr_xfer && pay_beat.last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DISCARD: begin
                    if (pay_valid && pay_beat.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // latch action for the whole packet
    always_ff @(posedge core_clk_ifc) begin
        if (act_valid && act_ready) begin
            cur <= act;
        end
    end

    a_one_port: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        $onehot0(egr_valid));

    // stalled beat holds, payload side included
    a_egr_hold: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        |(egr_valid & ~egr_ready) |=> $stable(egr_valid) && $stable(egr_beat));

endmodule

// ==== hdl/mpls_router_top.sv ====
//////////////////////////////
// label switch top: decode, execute, result
//////////////////////////////

`timescale 1ns/1ps

module mpls_router_top (
    input  logic                                                core_clk_ifc,
    input  logic                                                arst_n,
    input  net_pkg::axis_beat_t                                 in_beat,
    input  logic                                                in_valid,
    output logic                                                in_ready,
    output net_pkg::axis_beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    output logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_valid,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_ready,
    output logic [15:0]                                         drop_count,
    output logic [15:0]                                         runt_count
);

    // decode -> execute
    net_pkg::eth_mpls_hdr_t  hdr;
    logic                    hdr_valid;
    logic                    hdr_ready;
    // decode -> result
    net_pkg::axis_beat_t     pay_beat;
    logic                    pay_valid;
    logic                    pay_ready;
    // execute -> result
    router_pkg::fwd_action_t act;
    logic                    act_valid;
    logic                    act_ready;

    mpls_hdr_decode u_decode (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .runt_count   (runt_count)
    );

    label_switch_execute u_execute (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .act          (act),
        .act_valid    (act_valid),
        .act_ready    (act_ready),
        .drop_count   (drop_count)
    );

    egress_rewrite u_result (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .act          (act),
        .act_valid    (act_valid),
        .act_ready    (act_ready),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .egr_beat     (egr_beat),
        .egr_valid    (egr_valid),
        .egr_ready    (egr_ready)
    );

endmodule

// ==== test/mpls_router_checker.sv ====
//////////////////////////////
// reference model, per-port expected queues, egress compare
// end-of-run count checks and closing report
//////////////////////////////

`timescale 1ns/1ps

module mpls_router_checker (
    input  logic                                                core_clk_ifc,
    input  logic                                                arst_n,
    input  net_pkg::axis_beat_t                                 in_beat,
    input  logic                                                in_valid,
    input  logic                                                in_ready,
    input  net_pkg::axis_beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_valid,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_ready,
    input  logic [15:0]                                         drop_count,
    input  logic [15:0]                                         runt_count,
    input  logic                                                finish_req,
    output int                                                  error_count,
    output int                                                  pending_beats,
    output bit                                                  report_done
);

    // expected egress beats with one queue per port
    net_pkg::axis_beat_t   exp_q [router_pkg::NUM_EGR_PORTS][$];
    net_pkg::byte_t        hdr_buf [net_pkg::HDR_BYTES];
    int                    byte_pos;
    bit                    cur_fwd;
    router_pkg::port_idx_t cur_port;
    bit                    was_in_reset;
    int                    value_errors;
    int                    other_errors;
    int                    model_fwd;
    int                    model_drops;
    int                    model_runts;

    function automatic void push_exp(router_pkg::port_idx_t p, net_pkg::byte_t d, logic l);
        net_pkg::axis_beat_t b;
        b.data = d;
        b.last = l;
        exp_q[p].push_back(b);
    endfunction

    function automatic void value_error(string name, int p, logic [15:0] got, logic [15:0] exp);
        $display("FAILED %s (port %0d): got %h expected %h", name, p, got, exp);
        value_errors++;
    endfunction

    //////////////////////////////
    // forwarding rules on the 18 collected bytes
    //////////////////////////////
    function automatic void decide_packet(logic last);
        net_pkg::ether_type_t etype;
        net_pkg::mpls_label_t label;
        net_pkg::mpls_label_t new_label;
        net_pkg::mac_addr_t   dmac;
        bit                   hit;
        etype     = {hdr_buf[12], hdr_buf[13]};
        label     = {hdr_buf[14], hdr_buf[15], hdr_buf[16][7:4]};
        hit       = 1'b0;
        new_label = '0;
        cur_port  = '0;
        for (int i = 0; i < router_pkg::LABEL_ENTRIES; i++) begin
            if (!hit && router_pkg::LABEL_TABLE[i].in_label == label) begin
                hit       = 1'b1;
                new_label = router_pkg::LABEL_TABLE[i].out_label;
                cur_port  = router_pkg::LABEL_TABLE[i].port;
            end
        end
        // ttl of 0 or 1 would expire here
        cur_fwd = hit && (etype == net_pkg::ETHERTYPE_MPLS) && (hdr_buf[17] > 8'd1);
        if (!cur_fwd) begin
            model_drops++;
            return;
        end
        model_fwd++;
        dmac = router_pkg::NEXT_HOP_MAC[cur_port];
        for (int i = 0; i < 6; i++) begin
            push_exp(cur_port, dmac[47 - 8*i -: 8], 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            push_exp(cur_port, router_pkg::LOCAL_MAC[47 - 8*i -: 8], 1'b0);
        end
        push_exp(cur_port, hdr_buf[12], 1'b0);
        push_exp(cur_port, hdr_buf[13], 1'b0);
        push_exp(cur_port, new_label[19:12], 1'b0);
        push_exp(cur_port, new_label[11:4], 1'b0);
        // tc and s bit unchanged
        push_exp(cur_port, {new_label[3:0], hdr_buf[16][3:0]}, 1'b0);
        push_exp(cur_port, hdr_buf[17] - 8'd1, last);
    endfunction

    function automatic void take_ingress(net_pkg::axis_beat_t b);
        if (byte_pos < net_pkg::HDR_BYTES) begin
            hdr_buf[byte_pos] = b.data;
            if (byte_pos == net_pkg::HDR_BYTES - 1) begin
                decide_packet(b.last);
            end else if (b.last) begin
                model_runts++;
            end
        end else if (cur_fwd) begin
            // payload rides behind its header
            push_exp(cur_port, b.data, b.last);
        end
        byte_pos = b.last ? 0 : byte_pos + 1;
    endfunction

    function automatic void check_egress();
        net_pkg::axis_beat_t exp;
        for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
            if (egr_valid[p] && egr_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("ERROR: beat on port %0d while no packet was expected there", p);
                    other_errors++;
                end else begin
                    exp = exp_q[p].pop_front();
                    if (egr_beat[p].data !== exp.data) begin
                        value_error("egr_beat.data", p, 16'(egr_beat[p].data), 16'(exp.data));
                    end
                    if (egr_beat[p].last !== exp.last) begin
                        value_error("egr_beat.last", p, 16'(egr_beat[p].last), 16'(exp.last));
                    end
                end
            end
        end
    endfunction

    function automatic void check_reset_state();
        if (egr_valid !== '0) begin
            value_error("egr_valid", 0, 16'(egr_valid), 16'h0);
        end
        if (in_ready !== 1'b0) begin
            value_error("in_ready", 0, 16'(in_ready), 16'h0);
        end
        if (drop_count !== 16'h0) begin
            value_error("drop_count", 0, drop_count, 16'h0);
        end
        if (runt_count !== 16'h0) begin
            value_error("runt_count", 0, runt_count, 16'h0);
        end
    endfunction

    function automatic void final_report();
        if (drop_count !== 16'(model_drops)) begin
            value_error("drop_count", 0, drop_count, 16'(model_drops));
        end
        if (runt_count !== 16'(model_runts)) begin
            value_error("runt_count", 0, runt_count, 16'(model_runts));
        end
        error_count = value_errors + other_errors;
        $display("checker: errors=%0d value=%0d other=%0d fwd=%0d drops=%0d runts=%0d",
                 error_count, value_errors, other_errors, model_fwd, model_drops, model_runts);
        report_done = 1'b1;
    endfunction

    //////////////////////////////
    // monitor takes ingress before egress
    //////////////////////////////
    always @(posedge core_clk_ifc) begin
        if (!arst_n || was_in_reset) begin
            check_reset_state();
        end
        was_in_reset = !arst_n;
        if (arst_n && in_valid && in_ready) begin
            take_ingress(in_beat);
        end
        if (arst_n) begin
            check_egress();
        end
        pending_beats = 0;
        for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
            pending_beats += exp_q[p].size();
        end
        error_count = value_errors + other_errors;
        if (finish_req && !report_done) begin
            final_report();
        end
    end

endmodule

// ==== test/mpls_router_tb.sv ====
//////////////////////////////
// testbench top: clock, reset, random packets
// egress back-pressure, watchdog
//////////////////////////////

`timescale 1ns/1ps

module mpls_router_tb;

    localparam int NUM_PKTS     = 200;
    localparam int MAX_LEN      = 64;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_NS   = NUM_PKTS * MAX_LEN * 8 * CLK_PERIOD;

    logic                                                core_clk_ifc;
    logic                                                arst_n;
    net_pkg::axis_beat_t                                 in_beat;
    logic                                                in_valid;
    logic                                                in_ready;
    net_pkg::axis_beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat;
    logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_valid;
    logic [router_pkg::NUM_EGR_PORTS-1:0]                egr_ready;
    logic [15:0]                                         drop_count;
    logic [15:0]                                         runt_count;
    logic                                                finish_req;
    int                                                  error_count;
    int                                                  pending_beats;
    bit                                                  report_done;

    int             seed       = 32'h2f40e00c;
    // stall pattern gets its own stream
    int             ready_seed = 32'h2f40e00c ^ 32'h0000_5a5a;
    net_pkg::byte_t pkt [MAX_LEN];

    mpls_router_top u_dut (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .egr_beat     (egr_beat),
        .egr_valid    (egr_valid),
        .egr_ready    (egr_ready),
        .drop_count   (drop_count),
        .runt_count   (runt_count)
    );

    mpls_router_checker u_checker (
        .core_clk_ifc  (core_clk_ifc),
        .arst_n        (arst_n),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .egr_beat      (egr_beat),
        .egr_valid     (egr_valid),
        .egr_ready     (egr_ready),
        .drop_count    (drop_count),
        .runt_count    (runt_count),
        .finish_req    (finish_req),
        .error_count   (error_count),
        .pending_beats (pending_beats),
        .report_done   (report_done)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    function automatic int rand_range(int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    //////////////////////////////
    // packet generator
    //////////////////////////////
    task automatic build_packet(output int len);
        int                   kind;
        int                   ttl_sel;
        net_pkg::ether_type_t etype;
        net_pkg::mpls_label_t label;
        net_pkg::mpls_ttl_t   ttl;
        for (int i = 0; i < MAX_LEN; i++) begin
            pkt[i] = net_pkg::byte_t'($random(seed));
        end
        // runt, header only, or header plus payload
        kind = rand_range(8);
        if (kind == 0) begin
            len = 5 + rand_range(13);
        end else if (kind == 1) begin
            len = net_pkg::HDR_BYTES;
        end else begin
            len = net_pkg::HDR_BYTES + 1 + rand_range(MAX_LEN - net_pkg::HDR_BYTES);
        end
        etype = (rand_range(8) == 0) ? 16'h0800 : net_pkg::ETHERTYPE_MPLS;
        if (rand_range(5) == 0) begin
            label = 20'h0ab00 + 20'(rand_range(256));
        end else begin
            label = router_pkg::LABEL_TABLE[rand_range(router_pkg::LABEL_ENTRIES)].in_label;
        end
        ttl_sel = rand_range(6);
        ttl     = (ttl_sel < 3) ? net_pkg::mpls_ttl_t'(ttl_sel) : pkt[17];
        pkt[12] = etype[15:8];
        pkt[13] = etype[7:0];
        pkt[14] = label[19:12];
        pkt[15] = label[11:4];
        pkt[16] = {label[3:0], pkt[16][3:0]};
        pkt[17] = ttl;
    endtask

    // holds the beat until in_ready seen high before an edge
    task automatic wait_transfer();
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge core_clk_ifc);
            taken = in_ready;
            @(posedge core_clk_ifc);
        end
    endtask

    task automatic send_packet(int len);
        net_pkg::axis_beat_t beat;
        for (int i = 0; i < len; i++) begin
            if (rand_range(4) == 0) begin
                in_valid <= 1'b0;
                repeat (1 + rand_range(3)) @(posedge core_clk_ifc);
            end
            beat.data = pkt[i];
            beat.last = (i == len - 1);
            in_beat  <= beat;
            in_valid <= 1'b1;
            wait_transfer();
        end
        in_valid <= 1'b0;
    endtask

    // random egress stalls on both ports
    initial begin
        logic [router_pkg::NUM_EGR_PORTS-1:0] rdy;
        egr_ready = '0;
        forever begin
            @(posedge core_clk_ifc);
            for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
                rdy[p] = ($random(ready_seed) & 3) != 0;
            end
            egr_ready <= rdy;
        end
    end

    initial begin
        int len;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        finish_req = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        arst_n <= 1'b1;
        @(posedge core_clk_ifc);
        for (int n = 0; n < NUM_PKTS; n++) begin
            build_packet(len);
            send_packet(len);
        end
        // drain the egress side, then let the counters settle
        @(negedge core_clk_ifc);
        while (pending_beats != 0) @(negedge core_clk_ifc);
        repeat (20) @(posedge core_clk_ifc);
        finish_req <= 1'b1;
        @(negedge core_clk_ifc);
        while (!report_done) @(negedge core_clk_ifc);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: traffic did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/net_pkg.sv
hdl/router_pkg.sv
hdl/mpls_hdr_decode.sv
hdl/label_switch_execute.sv
hdl/egress_rewrite.sv
hdl/mpls_router_top.sv
test/mpls_router_checker.sv
test/mpls_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mpls router testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module mpls_router_tb \
    --Mdir obj_dir -o mpls_router_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/mpls_router_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "result: fail"; exit 1; } || { echo "result: pass"; exit 0; }
